/* include/arith_consts.svh */
// Fixed 16-bit datapath; buffer and queue depths must be powers of two for pointer wrap
`ifndef ARITH_CONSTS_SVH
`define ARITH_CONSTS_SVH

`define ARITH_WORD_W      16
`define ARITH_TAG_W       4
`define ARITH_REQ_CREDITS 2
`define ARITH_RSP_CREDITS 4
`define ARITH_MERGE_DEPTH 4
`define ARITH_DIV_STEPS   `ARITH_WORD_W

`endif

/* logic/arith_req_pkg.sv */
// Request side types; op codes above div_s are not expected and issue as an unsigned multiply
`include "arith_consts.svh"

package arith_req_pkg;

  typedef enum logic [2:0] {
    mul_u = 3'd0,
    mul_s = 3'd1,
    div_u = 3'd2,
    div_s = 3'd3
  } arith_op_e;

  typedef struct packed {
    arith_op_e                op;
    logic [`ARITH_TAG_W-1:0]  tag;
    logic [`ARITH_WORD_W-1:0] left;
    logic [`ARITH_WORD_W-1:0] right;
  } arith_req_t;

  // What a core sees, the op already decoded by dispatch
  typedef struct packed {
    logic [`ARITH_TAG_W-1:0]  tag;
    logic                     is_signed;
    logic [`ARITH_WORD_W-1:0] left;
    logic [`ARITH_WORD_W-1:0] right;
  } arith_issue_t;

endpackage

/* logic/arith_rsp_pkg.sv */
// Result side types; the data word is read as a product or a division result by is_div
`include "arith_consts.svh"

package arith_rsp_pkg;

  typedef struct packed {
    logic [`ARITH_WORD_W-1:0] hi;
    logic [`ARITH_WORD_W-1:0] lo;
  } arith_prod_t;

  typedef struct packed {
    logic [`ARITH_WORD_W-1:0] remainder;
    logic [`ARITH_WORD_W-1:0] quotient;
  } arith_divres_t;

  // Same bits, two readings
  typedef union packed {
    arith_prod_t   prod;
    arith_divres_t div;
  } arith_result_u;

  typedef struct packed {
    logic [`ARITH_TAG_W-1:0] tag;
    logic                    is_div;
    arith_result_u           data;
  } arith_core_rsp_t;

  // Record on the unit's response port
  typedef arith_core_rsp_t arith_rsp_t;

endpackage

/* logic/arith_dispatch.sv */
// In-order issue; a divide at the head blocks everything behind it until the divider is free
`timescale 1ns/100ps
`include "arith_consts.svh"

module arith_dispatch
  import arith_req_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         req_valid,
  input  arith_req_t   req,
  output logic         req_credit,
  input  logic         div_busy,
  input  logic         slot_credit,
  output logic         mult_issue_valid,
  output arith_issue_t mult_issue,
  output logic         div_issue_valid,
  output arith_issue_t div_issue
);

  localparam int PTR_W  = $clog2(`ARITH_REQ_CREDITS);
  localparam int CNT_W  = $clog2(`ARITH_REQ_CREDITS + 1);
  localparam int SLOT_W = $clog2(`ARITH_MERGE_DEPTH + 1);

  arith_req_t        buf_mem [`ARITH_REQ_CREDITS];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [SLOT_W-1:0] slots;
  arith_req_t        head;
  arith_issue_t      head_issue;
  logic              head_is_div;
  logic              issue;

  // Decode the head op into target core and signedness
  always_comb begin
    head                 = buf_mem[rd_ptr];
    head_is_div          = 1'b0;
    head_issue.tag       = head.tag;
    head_issue.is_signed = 1'b0;
    head_issue.left      = head.left;
    head_issue.right     = head.right;
    case (head.op)
      mul_s: head_issue.is_signed = 1'b1;
      div_u: head_is_div = 1'b1;
      div_s: begin
        head_is_div          = 1'b1;
        head_issue.is_signed = 1'b1;
      end
      default: head_is_div = 1'b0;
    endcase
  end

  // Every issue holds a reserved merge slot
  assign issue = (count != '0) && (slots != '0) && (!head_is_div || !div_busy);

  assign req_credit       = issue;
  assign mult_issue_valid = issue && !head_is_div;
  assign div_issue_valid  = issue && head_is_div;
  assign mult_issue       = head_issue;
  assign div_issue        = head_issue;

  always_ff @(posedge clk) begin
    if (req_valid) begin
      buf_mem[wr_ptr] <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      slots  <= SLOT_W'(`ARITH_MERGE_DEPTH);
    end else begin
      if (req_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (issue) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(req_valid) - CNT_W'(issue);
      slots <= slots + SLOT_W'(slot_credit) - SLOT_W'(issue);
    end
  end

  // Sender must hold a credit, so a full buffer never sees a new request
  a_req_within_credit: assert property (@(posedge clk) disable iff (rst)
    req_valid |-> (count < CNT_W'(`ARITH_REQ_CREDITS)));

endmodule

/* logic/arith_mult_pipe.sv */
// Three-cycle latency, one issue accepted every cycle; no stall path
`timescale 1ns/100ps
`include "arith_consts.svh"

module arith_mult_pipe
  import arith_req_pkg::*;
  import arith_rsp_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            issue_valid,
  input  arith_issue_t    issue,
  output logic            rsp_valid,
  output arith_core_rsp_t rsp
);

  localparam int W = `ARITH_WORD_W;

  logic                    s1_valid;
  logic                    s2_valid;
  logic [`ARITH_TAG_W-1:0] s1_tag;
  logic [`ARITH_TAG_W-1:0] s2_tag;
  logic [2*W-1:0]          s1_left;
  logic [2*W-1:0]          s1_right;
  logic [2*W-1:0]          s2_prod;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      s1_valid  <= issue_valid;
      s2_valid  <= s1_valid;
      rsp_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    // Extend to double width so one multiply serves both signednesses
    if (issue_valid) begin
      s1_tag   <= issue.tag;
      s1_left  <= {{W{issue.is_signed & issue.left[W-1]}}, issue.left};
      s1_right <= {{W{issue.is_signed & issue.right[W-1]}}, issue.right};
    end
    if (s1_valid) begin
      s2_tag  <= s1_tag;
      s2_prod <= s1_left * s1_right;
    end
    if (s2_valid) begin
      rsp.tag          <= s2_tag;
      rsp.is_div       <= 1'b0;
      rsp.data.prod.hi <= s2_prod[2*W-1:W];
      rsp.data.prod.lo <= s2_prod[W-1:0];
    end
  end

endmodule

/* logic/arith_div_iter.sv */
// One divide at a time, fixed latency of ARITH_DIV_STEPS+2; signed quotient truncates toward zero
`timescale 1ns/100ps
`include "arith_consts.svh"

module arith_div_iter
  import arith_req_pkg::*;
  import arith_rsp_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            issue_valid,
  input  arith_issue_t    issue,
  output logic            busy,
  output logic            rsp_valid,
  output arith_core_rsp_t rsp
);

  localparam int W     = `ARITH_WORD_W;
  localparam int CNT_W = $clog2(`ARITH_DIV_STEPS + 1);

  logic [CNT_W-1:0]        step_cnt;
  logic                    last_step;
  logic [`ARITH_TAG_W-1:0] op_tag;
  logic [W-1:0]            acc;
  logic [W-1:0]            quo;
  logic [W-1:0]            divisor;
  logic [W:0]              trial;
  logic [W:0]              diff;
  logic                    neg_q;
  logic                    neg_r;
  logic                    div_zero;
  logic                    left_neg;
  logic                    right_neg;
  logic [W-1:0]            left_mag;
  logic [W-1:0]            right_mag;

  assign left_neg  = issue.is_signed & issue.left[W-1];
  assign right_neg = issue.is_signed & issue.right[W-1];
  assign left_mag  = left_neg ? -issue.left : issue.left;
  assign right_mag = right_neg ? -issue.right : issue.right;

  // Partial remainder shifted left with the next dividend bit
  assign trial     = {acc, quo[W-1]};
  assign diff      = trial - {1'b0, divisor};
  assign last_step = (step_cnt == CNT_W'(`ARITH_DIV_STEPS));

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      rsp_valid <= 1'b0;
      step_cnt  <= '0;
    end else begin
      rsp_valid <= 1'b0;
      if (issue_valid) begin
        busy     <= 1'b1;
        step_cnt <= '0;
      end else if (busy) begin
        if (last_step) begin
          busy      <= 1'b0;
          rsp_valid <= 1'b1;
        end else begin
          step_cnt <= step_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      op_tag   <= issue.tag;
      acc      <= '0;
      quo      <= left_mag;
      divisor  <= right_mag;
      neg_q    <= left_neg ^ right_neg;
      neg_r    <= left_neg;
      div_zero <= (issue.right == '0);
    end else if (busy && !last_step) begin
      if (trial >= {1'b0, divisor}) begin
        acc <= diff[W-1:0];
        quo <= {quo[W-2:0], 1'b1};
      end else begin
        acc <= trial[W-1:0];
        quo <= {quo[W-2:0], 1'b0};
      end
    end else if (busy) begin
      // Sign fixup; with a zero divisor acc already holds the dividend magnitude
      rsp.tag                 <= op_tag;
      rsp.is_div              <= 1'b1;
      rsp.data.div.quotient   <= div_zero ? '1 : (neg_q ? -quo : quo);
      rsp.data.div.remainder  <= neg_r ? -acc : acc;
    end
  end

  // Dispatch must honour busy
  a_no_issue_when_busy: assert property (@(posedge clk) disable iff (rst)
    issue_valid |-> !busy);

  a_fixed_latency: assert property (@(posedge clk) disable iff (rst)
    $rose(busy) |-> ##(`ARITH_DIV_STEPS + 1) rsp_valid);

endmodule

/* logic/arith_result_merge.sv */
// Both cores may write in one cycle, multiplier first; room is guaranteed by dispatch slot credits
`timescale 1ns/100ps
`include "arith_consts.svh"

module arith_result_merge
  import arith_rsp_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            mult_valid,
  input  arith_core_rsp_t mult_rsp,
  input  logic            div_valid,
  input  arith_core_rsp_t div_rsp,
  input  logic            rsp_credit,
  output logic            rsp_valid,
  output arith_rsp_t      rsp,
  output logic            slot_credit
);

  localparam int DEPTH = `ARITH_MERGE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int CRD_W = $clog2(`ARITH_RSP_CREDITS + 1);

  arith_core_rsp_t  q_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] wr_ptr_nx;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] q_count;
  logic [CRD_W-1:0] credits;
  logic [1:0]       n_wr;
  logic             pop;

  assign wr_ptr_nx = wr_ptr + 1'b1;
  assign n_wr      = {1'b0, mult_valid} + {1'b0, div_valid};

  // Send the head whenever the receiver has room
  assign pop         = (q_count != '0) && (credits != '0);
  assign rsp_valid   = pop;
  assign rsp         = q_mem[rd_ptr];
  assign slot_credit = pop;

  always_ff @(posedge clk) begin
    if (mult_valid) begin
      q_mem[wr_ptr] <= mult_rsp;
    end
    if (div_valid) begin
      q_mem[mult_valid ? wr_ptr_nx : wr_ptr] <= div_rsp;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
      credits <= CRD_W'(`ARITH_RSP_CREDITS);
    end else begin
      wr_ptr <= wr_ptr + PTR_W'(n_wr);
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      q_count <= q_count + CNT_W'(n_wr) - CNT_W'(pop);
      credits <= credits + CRD_W'(rsp_credit) - CRD_W'(pop);
    end
  end

  // Holds only if dispatch never issues without a slot credit
  a_queue_no_overflow: assert property (@(posedge clk) disable iff (rst)
    (int'(q_count) + int'(n_wr) - int'(pop)) <= DEPTH);

  // Receiver returns no more credits than it was given
  a_credit_bound: assert property (@(posedge clk) disable iff (rst)
    credits <= CRD_W'(`ARITH_RSP_CREDITS));

endmodule

/* logic/arith_unit.sv */
// Responses may return out of order; match them to requests by tag
`timescale 1ns/100ps

module arith_unit
  import arith_req_pkg::*;
  import arith_rsp_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       req_valid,
  input  arith_req_t req,
  output logic       req_credit,
  output logic       rsp_valid,
  output arith_rsp_t rsp,
  input  logic       rsp_credit
);

  logic            mult_issue_valid;
  arith_issue_t    mult_issue;
  logic            div_issue_valid;
  arith_issue_t    div_issue;
  logic            div_busy;
  logic            slot_credit;
  logic            mult_rsp_valid;
  arith_core_rsp_t mult_rsp;
  logic            div_rsp_valid;
  arith_core_rsp_t div_rsp;

  arith_dispatch u_dispatch (
    .clk              (clk),
    .rst              (rst),
    .req_valid        (req_valid),
    .req              (req),
    .req_credit       (req_credit),
    .div_busy         (div_busy),
    .slot_credit      (slot_credit),
    .mult_issue_valid (mult_issue_valid),
    .mult_issue       (mult_issue),
    .div_issue_valid  (div_issue_valid),
    .div_issue        (div_issue)
  );

  arith_mult_pipe u_mult (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (mult_issue_valid),
    .issue       (mult_issue),
    .rsp_valid   (mult_rsp_valid),
    .rsp         (mult_rsp)
  );

  arith_div_iter u_div (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (div_issue_valid),
    .issue       (div_issue),
    .busy        (div_busy),
    .rsp_valid   (div_rsp_valid),
    .rsp         (div_rsp)
  );

  arith_result_merge u_merge (
    .clk         (clk),
    .rst         (rst),
    .mult_valid  (mult_rsp_valid),
    .mult_rsp    (mult_rsp),
    .div_valid   (div_rsp_valid),
    .div_rsp     (div_rsp),
    .rsp_credit  (rsp_credit),
    .rsp_valid   (rsp_valid),
    .rsp         (rsp),
    .slot_credit (slot_credit)
  );

endmodule

/* test/arith_checker.sv */
// Expected value comes from the table when given, else from the op rules; tags never reused while outstanding
`timescale 1ns/100ps
`include "arith_consts.svh"

module arith_checker
  import arith_req_pkg::*;
  import arith_rsp_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       req_valid,
  input  arith_req_t                 req,
  input  logic                       req_credit,
  input  logic                       rsp_valid,
  input  arith_rsp_t                 rsp,
  input  logic                       rsp_credit,
  input  logic                       exp_known,
  input  logic [2*`ARITH_WORD_W-1:0] exp_word,
  input  logic                       hold_phase,
  input  logic                       end_check,
  output int                         n_pass,
  output int                         n_fail,
  output int                         n_pending
);

  localparam int NTAGS = 1 << `ARITH_TAG_W;

  logic [2*`ARITH_WORD_W-1:0] exp_mem [NTAGS];
  arith_op_e                  op_mem  [NTAGS];
  logic                       pend    [NTAGS];
  logic                       want_div;
  int                         req_cr;
  int                         rsp_cr;
  int                         n_sent;
  int                         n_returned;
  int                         hold_rsps;

  // Reference rules, independent of the cores
  function automatic logic [31:0] expected_result(arith_op_e op, logic [15:0] l, logic [15:0] r);
    int          a;
    int          b;
    int          q;
    int          m;
    logic [31:0] p;
    a = int'($signed(l));
    b = int'($signed(r));
    case (op)
      mul_u: p = 32'(l) * 32'(r);
      mul_s: p = a * b;
      div_u: p = (r == '0) ? {l, 16'hffff} : {l % r, l / r};
      div_s: begin
        if (b == 0) begin
          p = {l, 16'hffff};
        end else begin
          // SV division truncates toward zero, remainder follows the dividend
          q = a / b;
          m = a % b;
          p = {m[15:0], q[15:0]};
        end
      end
      default: p = '0;
    endcase
    return p;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NTAGS; i++) begin
        pend[i] = 1'b0;
      end
      req_cr     = `ARITH_REQ_CREDITS;
      rsp_cr     = `ARITH_RSP_CREDITS;
      n_sent     = 0;
      n_returned = 0;
      hold_rsps  = 0;
      n_pass     = 0;
      n_fail     = 0;
      n_pending  = 0;
    end else begin
      if (rsp_valid) begin
        if (rsp_cr == 0) begin
          n_fail++;
          $display("DUT sent a response for tag %h without holding a credit", rsp.tag);
        end
        if (!pend[rsp.tag]) begin
          n_fail++;
          $display("response for tag %h arrived but that tag is not outstanding", rsp.tag);
        end else begin
          want_div = (op_mem[rsp.tag] == div_u) || (op_mem[rsp.tag] == div_s);
          if (rsp.is_div !== want_div) begin
            n_fail++;
            $display("CHECK FAILED rsp.is_div tag %h: got %h expected %h",
                     rsp.tag, rsp.is_div, want_div);
          end else if (rsp.data !== exp_mem[rsp.tag]) begin
            n_fail++;
            $display("CHECK FAILED rsp.data tag %h %s: got %h expected %h",
                     rsp.tag, op_mem[rsp.tag].name(), rsp.data, exp_mem[rsp.tag]);
          end else begin
            n_pass++;
            $display("ok tag %h %s result %h", rsp.tag, op_mem[rsp.tag].name(), rsp.data);
          end
          pend[rsp.tag] = 1'b0;
          n_pending--;
        end
      end
      if (req_valid) begin
        if (req_cr == 0) begin
          n_fail++;
          $display("request with tag %h was sent without a credit", req.tag);
        end
        if (pend[req.tag]) begin
          n_fail++;
          $display("tag %h was reused while still outstanding", req.tag);
        end
        pend[req.tag]    = 1'b1;
        op_mem[req.tag]  = req.op;
        exp_mem[req.tag] = exp_known ? exp_word : expected_result(req.op, req.left, req.right);
        n_pending++;
      end
      // Responses seen while no credit is returned
      if (hold_phase) begin
        if (rsp_valid) begin
          hold_rsps++;
          if (hold_rsps == `ARITH_RSP_CREDITS + 1) begin
            n_fail++;
            $display("more responses arrived than credits while credits were withheld");
          end
        end
      end else begin
        hold_rsps = 0;
      end
      req_cr     = req_cr + int'(req_credit) - int'(req_valid);
      rsp_cr     = rsp_cr + int'(rsp_credit) - int'(rsp_valid);
      n_sent     = n_sent + int'(req_valid);
      n_returned = n_returned + int'(req_credit);
      if (end_check) begin
        if (n_sent != n_returned) begin
          n_fail++;
          $display("request credits returned (%0d) differ from requests sent (%0d)",
                   n_returned, n_sent);
        end
        if (n_pending != 0) begin
          n_fail++;
          $display("%0d tags never came back", n_pending);
        end
      end
    end
  end

endmodule

/* test/tb_top.sv */
// Responses get one credit back per cycle; tags wrap after 16 requests
`timescale 1ns/100ps
`include "arith_consts.svh"

module tb_top
  import arith_req_pkg::*;
  import arith_rsp_pkg::*;
();

  localparam int NROWS      = 17;
  localparam int WAIT_LIMIT = 500;

  typedef struct packed {
    arith_op_e                  op;
    logic [`ARITH_WORD_W-1:0]   left;
    logic [`ARITH_WORD_W-1:0]   right;
    logic [2*`ARITH_WORD_W-1:0] result;
  } row_t;

  logic                       clk;
  logic                       rst;
  logic                       req_valid;
  arith_req_t                 req;
  logic                       req_credit;
  logic                       rsp_valid;
  arith_rsp_t                 rsp;
  logic                       rsp_credit;
  logic                       exp_known;
  logic [2*`ARITH_WORD_W-1:0] exp_word;
  logic                       hold_rsp;
  logic                       held;
  logic                       end_check;
  logic                       timed_out;
  logic [`ARITH_TAG_W-1:0]    next_tag;
  logic [31:0]                lfsr;
  row_t                       tbl [NROWS];
  int                         req_credits;
  int                         owed;
  int                         tb_errs;
  int                         n_pass;
  int                         n_fail;
  int                         n_pending;

  arith_unit u_dut (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req        (req),
    .req_credit (req_credit),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .rsp_credit (rsp_credit)
  );

  arith_checker u_chk (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req        (req),
    .req_credit (req_credit),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .rsp_credit (rsp_credit),
    .exp_known  (exp_known),
    .exp_word   (exp_word),
    .hold_phase (hold_rsp),
    .end_check  (end_check),
    .n_pass     (n_pass),
    .n_fail     (n_fail),
    .n_pending  (n_pending)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst) begin
      req_credits <= `ARITH_REQ_CREDITS;
    end else begin
      req_credits <= req_credits + int'(req_credit) - int'(req_valid);
    end
  end

  // Give back one response credit per cycle unless withheld
  initial begin
    rsp_credit = 1'b0;
    owed       = 0;
    forever begin
      @(posedge clk);
      held = hold_rsp;
      if (rst) begin
        owed = 0;
      end else if (rsp_valid) begin
        owed++;
      end
      #1;
      if (!held && owed > 0) begin
        rsp_credit = 1'b1;
        owed--;
      end else begin
        rsp_credit = 1'b0;
      end
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  task automatic draw_bits(input int n, output logic [15:0] v);
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[14:0], fb};
    end
  endtask

  task automatic fill_table();
    tbl[0]  = '{mul_u, 16'h0003, 16'h0005, 32'h0000_000f};
    tbl[1]  = '{mul_u, 16'hffff, 16'hffff, 32'hfffe_0001};
    tbl[2]  = '{mul_u, 16'h1234, 16'h0100, 32'h0012_3400};
    tbl[3]  = '{mul_s, 16'hfffd, 16'h0005, 32'hffff_fff1};
    tbl[4]  = '{mul_s, 16'hfffc, 16'hfffa, 32'h0000_0018};
    tbl[5]  = '{mul_s, 16'h8000, 16'h8000, 32'h4000_0000};
    tbl[6]  = '{mul_s, 16'h8000, 16'h0001, 32'hffff_8000};
    tbl[7]  = '{mul_s, 16'h8000, 16'hffff, 32'h0000_8000};
    // Division rows hold remainder then quotient
    tbl[8]  = '{div_u, 16'h0064, 16'h0007, 32'h0002_000e};
    tbl[9]  = '{div_u, 16'hffff, 16'h0010, 32'h000f_0fff};
    tbl[10] = '{div_u, 16'h1234, 16'h0000, 32'h1234_ffff};
    tbl[11] = '{div_s, 16'h0007, 16'h0002, 32'h0001_0003};
    tbl[12] = '{div_s, 16'hfff9, 16'h0002, 32'hffff_fffd};
    tbl[13] = '{div_s, 16'h0007, 16'hfffe, 32'h0001_fffd};
    tbl[14] = '{div_s, 16'hfff9, 16'hfffe, 32'hffff_0003};
    tbl[15] = '{div_s, 16'h8000, 16'h0007, 32'hffff_edb7};
    tbl[16] = '{div_s, 16'hfffb, 16'h0000, 32'hfffb_ffff};
  endtask

  task automatic send_request(input arith_op_e op, input logic [15:0] l, input logic [15:0] r,
                              input logic known, input logic [31:0] result);
    int t;
    t = 0;
    while (req_credits == 0 && !timed_out) begin
      @(posedge clk);
      #1;
      t++;
      if (t >= WAIT_LIMIT) begin
        timed_out = 1'b1;
        $display("no request credit came back within %0d cycles", WAIT_LIMIT);
      end
    end
    if (!timed_out) begin
      req_valid = 1'b1;
      req       = '{op, next_tag, l, r};
      exp_known = known;
      exp_word  = result;
      next_tag  = next_tag + 1'b1;
      @(posedge clk);
      #1;
      req_valid = 1'b0;
      exp_known = 1'b0;
    end
  endtask

  task automatic wait_drained(input string what);
    int t;
    t = 0;
    while (!timed_out && (n_pending != 0 || req_credits != `ARITH_REQ_CREDITS)) begin
      @(posedge clk);
      #1;
      t++;
      if (t >= WAIT_LIMIT) begin
        timed_out = 1'b1;
        $display("requests still outstanding %0d cycles after the %s phase", WAIT_LIMIT, what);
      end
    end
  endtask

  task automatic run_random(input int count);
    logic [15:0] op_bits;
    logic [15:0] l;
    logic [15:0] r;
    for (int i = 0; i < count && !timed_out; i++) begin
      draw_bits(2, op_bits);
      draw_bits(16, l);
      draw_bits(16, r);
      send_request(arith_op_e'({1'b0, op_bits[1:0]}), l, r, 1'b0, '0);
    end
  endtask

  // Multiplies only, so the queue fills quickly
  task automatic run_backpressure(input int cycles);
    logic [15:0] op_bits;
    logic [15:0] l;
    logic [15:0] r;
    logic        saw_empty;
    saw_empty = 1'b0;
    hold_rsp  = 1'b1;
    for (int c = 0; c < cycles && !timed_out; c++) begin
      if (req_credits > 0) begin
        draw_bits(1, op_bits);
        draw_bits(16, l);
        draw_bits(16, r);
        send_request(op_bits[0] ? mul_s : mul_u, l, r, 1'b0, '0);
      end else begin
        saw_empty = 1'b1;
        @(posedge clk);
        #1;
      end
    end
    hold_rsp = 1'b0;
    if (!saw_empty) begin
      tb_errs++;
      $display("back-pressure never reached the sender while credits were withheld");
    end
  endtask

  initial begin
    rst       = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    exp_known = 1'b0;
    exp_word  = '0;
    hold_rsp  = 1'b0;
    end_check = 1'b0;
    timed_out = 1'b0;
    next_tag  = '0;
    tb_errs   = 0;
    lfsr      = 32'hb62b;
    fill_table();
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int i = 0; i < NROWS && !timed_out; i++) begin
      send_request(tbl[i].op, tbl[i].left, tbl[i].right, 1'b1, tbl[i].result);
    end
    wait_drained("table");
    run_random(40);
    wait_drained("random");
    run_backpressure(60);
    wait_drained("back-pressure");

    end_check = 1'b1;
    @(posedge clk);
    #1;
    end_check = 1'b0;
    @(posedge clk);
    #1;

    $display("%0d responses correct, %0d errors", n_pass, n_fail + tb_errs);
    if (!timed_out && n_fail == 0 && tb_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+include
logic/arith_req_pkg.sv
logic/arith_rsp_pkg.sv
logic/arith_dispatch.sv
logic/arith_mult_pipe.sv
logic/arith_div_iter.sv
logic/arith_result_merge.sv
logic/arith_unit.sv
test/arith_checker.sv
test/tb_top.sv

/* Makefile */
SRCS := all.f $(wildcard logic/*.sv test/*.sv include/*.svh)

.PHONY: all run clean

all: obj_dir/Vtb_top

obj_dir/Vtb_top: $(SRCS)
	verilator --binary --timing --assert -f all.f --top-module tb_top -o Vtb_top

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top > sim.log 2>&1 || true
	cat sim.log
	! grep -q "SIMULATION FAILED" sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
